/* hw/dma_config.svh */
// widths, channel count and APB register offsets of the DMA register block
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

`define DMA_CHANNELS 4
`define DMA_WORD_W 16
`define DMA_BYTE_W 8
`define DMA_PADDR_W 4

// offsets 0 to 7 hold channel n address at 2n and count at 2n+1
`define DMA_OFS_STATUS 8
`define DMA_OFS_SINGLE_MASK 10
`define DMA_OFS_MODE 11
`define DMA_OFS_CLEAR_FF 12
`define DMA_OFS_MASTER_CLEAR 13
`define DMA_OFS_CLEAR_MASK 14
`define DMA_OFS_ALL_MASK 15

`endif

/* hw/dmaPkg.sv */
// channel index, word, byte, mode and register select types of the DMA register block
`include "dma_config.svh"

package dmaPkg;

        typedef logic [$clog2(`DMA_CHANNELS)-1:0] chanIdx;
        typedef logic [`DMA_WORD_W-1:0] dmaWord;
        typedef logic [`DMA_BYTE_W-1:0] dmaByte;

        // mode bits 4 and 5 of an 8237 mode write
        typedef struct packed {
                logic autoInit;
                logic decrement;
        } modeBits;

        // register or command addressed by one APB access
        typedef enum logic [3:0] {
                selNone,
                selAddr,
                selCount,
                selStatus,
                selMode,
                selSingleMask,
                selAllMask,
                selClearFf,
                selMasterClear,
                selClearMask
        } regSel;

endpackage

/* hw/dmaIfs.sv */
// register access interface and transfer step interface with their modports
`timescale 1ns/1ps
`include "dma_config.svh"

interface regAccessIf;
        logic cmdValid;
        logic cmdWrite;
        logic [3:0] sel;
        logic [$clog2(`DMA_CHANNELS)-1:0] chan;
        logic [`DMA_BYTE_W-1:0] wData;
        logic [`DMA_BYTE_W-1:0] rData;

        modport source (output cmdValid, cmdWrite, sel, chan, wData, input rData);
        modport sink (input cmdValid, cmdWrite, sel, chan, wData, output rData);
endinterface

interface stepIf;
        // read side, one channel looked up per cycle
        logic [$clog2(`DMA_CHANNELS)-1:0] rdChan;
        logic [`DMA_WORD_W-1:0] curAddr;
        logic [`DMA_WORD_W-1:0] curCount;
        logic [`DMA_WORD_W-1:0] baseAddr;
        logic [`DMA_WORD_W-1:0] baseCount;
        logic [1:0] mode;
        logic masked;
        // write-back side
        logic wbValid;
        logic [$clog2(`DMA_CHANNELS)-1:0] wbChan;
        logic [`DMA_WORD_W-1:0] newAddr;
        logic [`DMA_WORD_W-1:0] newCount;
        logic wbTc;
        logic wbMaskSet;

        modport engine (output rdChan, wbValid, wbChan, newAddr, newCount, wbTc, wbMaskSet,
                        input curAddr, curCount, baseAddr, baseCount, mode, masked);
        modport regs (input rdChan, wbValid, wbChan, newAddr, newCount, wbTc, wbMaskSet,
                      output curAddr, curCount, baseAddr, baseCount, mode, masked);
endinterface

/* hw/apbRegDecode.sv */
// APB slave stage that turns each access into a register command and returns read data
`timescale 1ns/1ps
`include "dma_config.svh"

module apbRegDecode (
        input  logic                     dma_if,
        input  logic                     reset,
        input  logic                     pSel,
        input  logic                     pEnable,
        input  logic                     pWrite,
        input  logic [`DMA_PADDR_W-1:0]  pAddr,
        input  dmaPkg::dmaByte           pWdata,
        output dmaPkg::dmaByte           pRdata,
        output logic                     pReady,
        output logic                     pSlverr,
        regAccessIf.source               acc
);
        dmaPkg::regSel decSel;
        logic accessPhase;
        logic badAccess;

        // map the offset onto the 8237 register layout
        always_comb
        begin
                decSel = dmaPkg::selNone;
                if (pAddr < `DMA_OFS_STATUS)
                        decSel = pAddr[0] ? dmaPkg::selCount : dmaPkg::selAddr;
                else
                begin
                        case (pAddr)
                                `DMA_OFS_STATUS:       decSel = dmaPkg::selStatus;
                                `DMA_OFS_SINGLE_MASK:  decSel = dmaPkg::selSingleMask;
                                `DMA_OFS_MODE:         decSel = dmaPkg::selMode;
                                `DMA_OFS_CLEAR_FF:     decSel = dmaPkg::selClearFf;
                                `DMA_OFS_MASTER_CLEAR: decSel = dmaPkg::selMasterClear;
                                `DMA_OFS_CLEAR_MASK:   decSel = dmaPkg::selClearMask;
                                `DMA_OFS_ALL_MASK:     decSel = dmaPkg::selAllMask;
                                default:               decSel = dmaPkg::selNone;
                        endcase
                end
        end

        // status is read only, offset 9 is a hole
        assign badAccess = (decSel == dmaPkg::selNone) || (decSel == dmaPkg::selStatus && pWrite);
        assign accessPhase = pSel && pEnable;

        assign acc.sel = decSel;
        assign acc.chan = pAddr[$clog2(`DMA_CHANNELS):1];
        assign acc.wData = pWdata;
        assign acc.cmdWrite = pWrite;
        assign acc.cmdValid = accessPhase && !badAccess;

        // no wait states
        assign pReady = accessPhase;
        assign pSlverr = accessPhase && badAccess;

        // read byte is taken at the end of setup and held through the access phase
        always_ff @(posedge dma_if)
        begin
                if (pSel && !pEnable)
                        pRdata <= acc.rData;
        end

        apbSetupFirst: assert property (@(posedge dma_if) disable iff (reset)
                $rose(pEnable) |-> $past(pSel && !pEnable));

endmodule

/* hw/channelRegFile.sv */
// per-channel address and count registers, mode, mask, TC flags, byte flip-flop and commands
`timescale 1ns/1ps
`include "dma_config.svh"

module channelRegFile (
        input  logic       dma_if,
        input  logic       reset,
        regAccessIf.sink   acc,
        stepIf.regs        step
);
        dmaPkg::dmaWord baseAddr [`DMA_CHANNELS];
        dmaPkg::dmaWord curAddr [`DMA_CHANNELS];
        dmaPkg::dmaWord baseCount [`DMA_CHANNELS];
        dmaPkg::dmaWord curCount [`DMA_CHANNELS];
        dmaPkg::modeBits mode [`DMA_CHANNELS];
        logic [`DMA_CHANNELS-1:0] mask;
        logic [`DMA_CHANNELS-1:0] tcFlag;
        logic byteFf;
        logic masterClear;
        dmaPkg::chanIdx dataChan;

        function automatic dmaPkg::dmaByte pickByte(input dmaPkg::dmaWord w, input logic hi);
                return hi ? w[`DMA_WORD_W-1:`DMA_BYTE_W] : w[`DMA_BYTE_W-1:0];
        endfunction

        function automatic dmaPkg::dmaWord putByte(input dmaPkg::dmaWord w,
                                                   input dmaPkg::dmaByte b, input logic hi);
                dmaPkg::dmaWord r;
                r = w;
                if (hi)
                        r[`DMA_WORD_W-1:`DMA_BYTE_W] = b;
                else
                        r[`DMA_BYTE_W-1:0] = b;
                return r;
        endfunction

        // mode and single mask writes carry the channel in data bits 1:0
        assign dataChan = acc.wData[1:0];
        assign masterClear = acc.cmdValid && acc.cmdWrite && !step.wbValid
                             && acc.sel == dmaPkg::selMasterClear;

        always_ff @(posedge dma_if)
        begin
                if (reset || masterClear)
                begin
                        for (int i = 0; i < `DMA_CHANNELS; i++)
                        begin
                                baseAddr[i] <= '0;
                                curAddr[i] <= '0;
                                baseCount[i] <= '0;
                                curCount[i] <= '0;
                                mode[i] <= '0;
                        end
                        // master clear leaves every channel masked, as on the 8237
                        mask <= reset ? '0 : '1;
                        tcFlag <= '0;
                        byteFf <= 1'b0;
                end
                else if (step.wbValid)
                begin
                        curAddr[step.wbChan] <= step.newAddr;
                        curCount[step.wbChan] <= step.newCount;
                        if (step.wbTc)
                                tcFlag[step.wbChan] <= 1'b1;
                        if (step.wbMaskSet)
                                mask[step.wbChan] <= 1'b1;
                end
                else if (acc.cmdValid)
                begin
                        case (acc.sel)
                                dmaPkg::selAddr, dmaPkg::selCount:
                                begin
                                        byteFf <= !byteFf;
                                        if (acc.cmdWrite && acc.sel == dmaPkg::selAddr)
                                        begin
                                                baseAddr[acc.chan] <= putByte(baseAddr[acc.chan],
                                                                              acc.wData, byteFf);
                                                curAddr[acc.chan] <= putByte(curAddr[acc.chan],
                                                                             acc.wData, byteFf);
                                        end
                                        else if (acc.cmdWrite)
                                        begin
                                                baseCount[acc.chan] <= putByte(baseCount[acc.chan],
                                                                               acc.wData, byteFf);
                                                curCount[acc.chan] <= putByte(curCount[acc.chan],
                                                                              acc.wData, byteFf);
                                        end
                                end
                                // read clears the TC flags
                                dmaPkg::selStatus: tcFlag <= '0;
                                dmaPkg::selMode:
                                        if (acc.cmdWrite)
                                                mode[dataChan] <= '{autoInit: acc.wData[4],
                                                                    decrement: acc.wData[5]};
                                dmaPkg::selSingleMask:
                                        if (acc.cmdWrite)
                                                mask[dataChan] <= acc.wData[2];
                                dmaPkg::selAllMask:
                                        if (acc.cmdWrite)
                                                mask <= acc.wData[`DMA_CHANNELS-1:0];
                                dmaPkg::selClearFf:
                                        if (acc.cmdWrite)
                                                byteFf <= 1'b0;
                                dmaPkg::selClearMask:
                                        if (acc.cmdWrite)
                                                mask <= '0;
                                default: ;
                        endcase
                end
        end

        // read byte for the APB stage, status bits 7:4 read as zero
        always_comb
        begin
                case (acc.sel)
                        dmaPkg::selAddr:   acc.rData = pickByte(curAddr[acc.chan], byteFf);
                        dmaPkg::selCount:  acc.rData = pickByte(curCount[acc.chan], byteFf);
                        dmaPkg::selStatus: acc.rData = dmaPkg::dmaByte'(tcFlag);
                        default:           acc.rData = '0;
                endcase
        end

        assign step.curAddr = curAddr[step.rdChan];
        assign step.curCount = curCount[step.rdChan];
        assign step.baseAddr = baseAddr[step.rdChan];
        assign step.baseCount = baseCount[step.rdChan];
        assign step.mode = mode[step.rdChan];
        assign step.masked = mask[step.rdChan];

        noApbDuringWriteBack: assert property (@(posedge dma_if) disable iff (reset)
                !(acc.cmdValid && step.wbValid));

endmodule

/* hw/transferStep.sv */
// two-stage pipeline that advances one channel address and count per accepted step
`timescale 1ns/1ps
`include "dma_config.svh"

module transferStep (
        input  logic            dma_if,
        input  logic            reset,
        input  logic            stepValid,
        input  dmaPkg::chanIdx  stepChannel,
        input  logic            pSel,
        input  logic            pEnable,
        output logic            stepReady,
        output logic            stepDone,
        output logic            stepTc,
        output dmaPkg::dmaWord  stepAddr,
        stepIf.engine           step
);
        logic s1Valid;
        dmaPkg::chanIdx s1Chan;
        logic s2Valid;
        dmaPkg::chanIdx s2Chan;
        dmaPkg::dmaWord s2OldAddr;
        dmaPkg::dmaWord s2NewAddr;
        dmaPkg::dmaWord s2NewCount;
        logic s2Tc;
        logic s2MaskSet;
        logic s2Write;
        logic accepted;
        logic atTc;
        dmaPkg::modeBits chanMode;
        dmaPkg::dmaWord nextAddr;

        assign stepReady = !s1Valid && !s2Valid && !(pSel && pEnable);
        assign accepted = stepValid && stepReady;

        // stage 1 looks at the registers of the sampled channel
        assign step.rdChan = s1Chan;
        assign chanMode = step.mode;
        assign atTc = (step.curCount == '0);
        assign nextAddr = chanMode.decrement ? step.curAddr - 1'b1 : step.curAddr + 1'b1;

        always_ff @(posedge dma_if)
        begin
                if (reset)
                begin
                        s1Valid <= 1'b0;
                        s2Valid <= 1'b0;
                end
                else
                begin
                        s1Valid <= accepted;
                        s2Valid <= s1Valid;
                end
        end

        always_ff @(posedge dma_if)
        begin
                if (accepted)
                        s1Chan <= stepChannel;
                s2Chan <= s1Chan;
                s2OldAddr <= step.curAddr;
                s2Write <= !step.masked;
                s2Tc <= !step.masked && atTc;
                s2MaskSet <= atTc && !chanMode.autoInit;
                // autoinitialize reloads on TC, otherwise count wraps to all ones
                if (atTc && chanMode.autoInit)
                begin
                        s2NewAddr <= step.baseAddr;
                        s2NewCount <= step.baseCount;
                end
                else
                begin
                        s2NewAddr <= nextAddr;
                        s2NewCount <= step.curCount - 1'b1;
                end
        end

        // stage 2 writes back and reports
        assign step.wbValid = s2Valid && s2Write;
        assign step.wbChan = s2Chan;
        assign step.newAddr = s2NewAddr;
        assign step.newCount = s2NewCount;
        assign step.wbTc = s2Tc;
        assign step.wbMaskSet = s2MaskSet;

        assign stepDone = s2Valid;
        assign stepTc = s2Valid && s2Tc;
        assign stepAddr = s2OldAddr;

        // the registers sampled in stage 1 must stay untouched by APB until write-back
        noApbWhileStepping: assert property (@(posedge dma_if) disable iff (reset)
                (s1Valid || s2Valid) |-> !(pSel && pEnable));

endmodule

/* hw/dmaRegisters.sv */
// top level of the DMA register block, APB decode, channel registers and step pipeline
`timescale 1ns/1ps
`include "dma_config.svh"

module dmaRegisters (
        input  logic                     dma_if,
        input  logic                     reset,
        input  logic                     pSel,
        input  logic                     pEnable,
        input  logic                     pWrite,
        input  logic [`DMA_PADDR_W-1:0]  pAddr,
        input  dmaPkg::dmaByte           pWdata,
        output dmaPkg::dmaByte           pRdata,
        output logic                     pReady,
        output logic                     pSlverr,
        input  logic                     stepValid,
        input  dmaPkg::chanIdx           stepChannel,
        output logic                     stepReady,
        output logic                     stepDone,
        output logic                     stepTc,
        output dmaPkg::dmaWord           stepAddr
);
        regAccessIf accBus ();
        stepIf stepBus ();

        apbRegDecode decode_i (
                .dma_if  (dma_if),
                .reset   (reset),
                .pSel    (pSel),
                .pEnable (pEnable),
                .pWrite  (pWrite),
                .pAddr   (pAddr),
                .pWdata  (pWdata),
                .pRdata  (pRdata),
                .pReady  (pReady),
                .pSlverr (pSlverr),
                .acc     (accBus.source)
        );

        channelRegFile regs_i (
                .dma_if (dma_if),
                .reset  (reset),
                .acc    (accBus.sink),
                .step   (stepBus.regs)
        );

        // the step pipeline stalls while an APB access phase is on the bus
        transferStep step_i (
                .dma_if      (dma_if),
                .reset       (reset),
                .stepValid   (stepValid),
                .stepChannel (stepChannel),
                .pSel        (pSel),
                .pEnable     (pEnable),
                .stepReady   (stepReady),
                .stepDone    (stepDone),
                .stepTc      (stepTc),
                .stepAddr    (stepAddr),
                .step        (stepBus.engine)
        );

endmodule

/* test/dmaRegistersTb.sv */
// testbench for the DMA register block that replays APB and step operations from a data file
`timescale 1ns/1ps
`include "dma_config.svh"

module dmaRegistersTb;
        localparam int maxOps = 64;
        localparam int waitLimit = 20;

        logic dma_if;
        logic reset;
        logic pSel;
        logic pEnable;
        logic pWrite;
        logic [`DMA_PADDR_W-1:0] pAddr;
        dmaPkg::dmaByte pWdata;
        dmaPkg::dmaByte pRdata;
        logic pReady;
        logic pSlverr;
        logic stepValid;
        dmaPkg::chanIdx stepChannel;
        logic stepReady;
        logic stepDone;
        logic stepTc;
        dmaPkg::dmaWord stepAddr;

        // one word per operation holding test, kind, offset or channel, value and flag
        logic [31:0] ops [maxOps];
        logic [31:0] op;
        int idx;
        int errors;
        int testStartErrors;
        int testsRun;
        int opsRun;
        logic endSeen;

        dmaRegisters dut_i (
                .dma_if      (dma_if),
                .reset       (reset),
                .pSel        (pSel),
                .pEnable     (pEnable),
                .pWrite      (pWrite),
                .pAddr       (pAddr),
                .pWdata      (pWdata),
                .pRdata      (pRdata),
                .pReady      (pReady),
                .pSlverr     (pSlverr),
                .stepValid   (stepValid),
                .stepChannel (stepChannel),
                .stepReady   (stepReady),
                .stepDone    (stepDone),
                .stepTc      (stepTc),
                .stepAddr    (stepAddr)
        );

        always #20 dma_if = ~dma_if;

        // setup, access, then the result is sampled at the falling edge after the access phase
        task automatic apbTransfer(input logic write, input logic [`DMA_PADDR_W-1:0] offset,
                                   input dmaPkg::dmaByte data, output dmaPkg::dmaByte rdata,
                                   output logic err);
                @(negedge dma_if);
                pSel = 1'b1;
                pEnable = 1'b0;
                pWrite = write;
                pAddr = offset;
                pWdata = data;
                @(negedge dma_if);
                pEnable = 1'b1;
                @(negedge dma_if);
                if (pReady !== 1'b1)
                begin
                        $display("Mismatch pReady: got %h, expected 1", pReady);
                        errors++;
                end
                // no step may start while an access phase is on the bus
                if (stepReady !== 1'b0)
                begin
                        $display("Mismatch stepReady: got %h, expected 0", stepReady);
                        errors++;
                end
                rdata = pRdata;
                err = pSlverr;
                pSel = 1'b0;
                pEnable = 1'b0;
                pWrite = 1'b0;
        endtask

        task automatic runStep(input dmaPkg::chanIdx chan, output dmaPkg::dmaWord addr,
                               output logic tc, output logic ok);
                int waited;
                ok = 1'b0;
                addr = '0;
                tc = 1'b0;
                waited = 0;
                @(negedge dma_if);
                while (!stepReady && waited < waitLimit)
                begin
                        @(negedge dma_if);
                        waited++;
                end
                if (!stepReady)
                begin
                        $display("timeout: stepReady stayed low for %0d cycles", waitLimit);
                        return;
                end
                stepValid = 1'b1;
                stepChannel = chan;
                @(negedge dma_if);
                stepValid = 1'b0;
                waited = 0;
                while (!stepDone && waited < waitLimit)
                begin
                        @(negedge dma_if);
                        waited++;
                end
                if (!stepDone)
                begin
                        $display("timeout: no stepDone within %0d cycles of a step", waitLimit);
                        return;
                end
                // stepDone belongs two cycles after acceptance
                if (waited != 1)
                begin
                        $display("stepDone came in cycle %0d after acceptance instead of cycle 2",
                                 waited + 1);
                        errors++;
                end
                addr = stepAddr;
                tc = stepTc;
                ok = 1'b1;
        endtask

        // replays one data line and compares the DUT response with its expected values
        task automatic runOperation(input logic [31:0] line, input int lineNo);
                dmaPkg::dmaByte gotData;
                logic gotErr;
                dmaPkg::dmaWord gotAddr;
                logic gotTc;
                logic stepOk;
                case (line[27:24])
                        4'h1:
                        begin
                                apbTransfer(1'b1, line[23:20], line[11:4], gotData, gotErr);
                                if (gotErr !== line[0])
                                begin
                                        $display("Mismatch pSlverr: got %h, expected %h",
                                                 gotErr, line[0]);
                                        errors++;
                                end
                        end
                        4'h2:
                        begin
                                apbTransfer(1'b0, line[23:20], 8'h00, gotData, gotErr);
                                if (gotData !== line[11:4])
                                begin
                                        $display("Mismatch pRdata: got %h, expected %h",
                                                 gotData, line[11:4]);
                                        errors++;
                                end
                                if (gotErr !== line[0])
                                begin
                                        $display("Mismatch pSlverr: got %h, expected %h",
                                                 gotErr, line[0]);
                                        errors++;
                                end
                        end
                        4'h3:
                        begin
                                runStep(line[21:20], gotAddr, gotTc, stepOk);
                                if (!stepOk)
                                        errors++;
                                if (stepOk && gotAddr !== line[19:4])
                                begin
                                        $display("Mismatch stepAddr: got %h, expected %h",
                                                 gotAddr, line[19:4]);
                                        errors++;
                                end
                                if (stepOk && gotTc !== line[0])
                                begin
                                        $display("Mismatch stepTc: got %h, expected %h",
                                                 gotTc, line[0]);
                                        errors++;
                                end
                        end
                        default:
                        begin
                                $display("unknown operation kind on data line %0d", lineNo);
                                errors++;
                        end
                endcase
        endtask

        initial
        begin
                dma_if = 1'b0;
                reset = 1'b1;
                pSel = 1'b0;
                pEnable = 1'b0;
                pWrite = 1'b0;
                pAddr = '0;
                pWdata = '0;
                stepValid = 1'b0;
                stepChannel = '0;
                errors = 0;
                testStartErrors = 0;
                testsRun = 0;
                opsRun = 0;
                endSeen = 1'b0;
                $readmemh("test/dmaTestdata.txt", ops);
                repeat (16) @(posedge dma_if);
                @(negedge dma_if);
                reset = 1'b0;

                idx = 0;
                while (!endSeen && idx < maxOps)
                begin
                        op = ops[idx];
                        if (op[27:24] == 4'hf)
                                endSeen = 1'b1;
                        else
                        begin
                                opsRun++;
                                runOperation(op, idx);
                                // a test ends where the next line carries another test number
                                if (idx + 1 >= maxOps || ops[idx + 1][31:28] !== op[31:28])
                                begin
                                        $display("test %0d finished with %0d errors", op[31:28],
                                                 errors - testStartErrors);
                                        testStartErrors = errors;
                                        testsRun++;
                                end
                        end
                        idx++;
                end
                if (!endSeen)
                begin
                        $display("the test data ended without its end marker");
                        errors++;
                end

                $display("%0d tests, %0d operations, %0d errors", testsRun, opsRun, errors);
                if (errors == 0)
                        $display("No errors");
                else
                        $display("Errors found");
                $finish;
        end

endmodule

/* test/dmaTestdata.txt */
// one operation per line as hex digits T K S VVVV F: test number, kind (1 write, 2 read,
// 3 step, f end), offset or channel, data or expected value, expected pSlverr or stepTc
// test 1: byte pointer on channel 0 address and count
11000340
11000120
11100050
11c00000
11100020
11100000
11c00000
12000340
12000120
12100020
12100000
// test 2: unmapped offset and a status write
22900001
21800ff1
22000340
22000120
// test 3: channel 0 counts down to TC, channel 1 set up for decrement
33012340
33012350
33012361
32800010
32800000
31200000
31200010
31300010
31300000
31b00310
33101000
// test 4: autoinitialize reload on channel 1, channel 0 left masked
43100ff1
42200000
42200010
42300010
42300000
42800020
43012370
// test 5: mask commands and master clear
51e00000
53012370
51a00040
53012380
51f000e0
53012380
53012390
51d00000
52000000
52000000
52800000
53000000
53300000
0f000000

/* all.f */
+incdir+hw
hw/dmaPkg.sv
hw/dmaIfs.sv
hw/apbRegDecode.sv
hw/channelRegFile.sv
hw/transferStep.sv
hw/dmaRegisters.sv
test/dmaRegistersTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the DMA register block testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
        --top-module dmaRegistersTb -Mdir obj_dir -o dmaSim
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/dmaSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
        echo "simulation exited with status $simStatus"
        exit 1
fi

if grep -qx "No errors" "$logFile"; then
        exit 0
fi
echo "pass message not found in $logFile"
exit 1
